// File: verilog/trng_pkg.sv
`default_nettype none

package trng_pkg;

    localparam int temp_width      = 12;  // ro counter and threshold
    localparam int num_temp        = 4;   // monitors around the die
    localparam int output_width    = 16;  // rand_byte pins
    localparam int num_sources     = 64;  // 0..31 latch, 32..63 jitter
    localparam int spi_frame_width = 16;  // wr bit + addr + data

    // request codes seen on the rand_req_type pins
    typedef enum logic [2:0] {
        req_raw    = 3'd0,  // one collected word
        req_xor    = 3'd1,  // two words folded together
        req_status = 3'd2   // alarm flags only
    } rand_req_t;

    // spi register map
    localparam logic [2:0] addr_thresh_0 = 3'd0;
    localparam logic [2:0] addr_thresh_1 = 3'd1;
    localparam logic [2:0] addr_thresh_2 = 3'd2;
    localparam logic [2:0] addr_thresh_3 = 3'd3;
    localparam logic [2:0] addr_mask_lo  = 3'd4;  // excludes sources 0..11
    localparam logic [2:0] addr_mask_hi  = 3'd5;  // excludes sources 32..43

endpackage

`default_nettype wire

// File: verilog/spi_cfg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module spi_cfg_regs (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             ss_n,
    input  logic                             sck,
    input  logic                             mosi,
    output logic                             miso,
    output logic                             spi_data_ready,
    output logic [trng_pkg::temp_width-1:0]  thresh_0,
    output logic [trng_pkg::temp_width-1:0]  thresh_1,
    output logic [trng_pkg::temp_width-1:0]  thresh_2,
    output logic [trng_pkg::temp_width-1:0]  thresh_3,
    output logic [trng_pkg::num_sources-1:0] source_mask
);

    localparam int fw    = trng_pkg::spi_frame_width;
    localparam int dw    = trng_pkg::temp_width;       // data field
    localparam int cw    = $clog2(fw + 1);             // counts 0..16
    localparam int pad_w = trng_pkg::num_sources / 2 - dw;

    logic [2:0]    sync_1;     // {ss_n, sck, mosi} first stage
    logic [2:0]    sync_2;     // same, second stage
    logic          sck_prev;
    logic          ss_prev;
    logic          sck_rise;
    logic          sck_fall;
    logic          frame_end;
    logic          frame_ok;   // exactly 16 bits seen
    logic [fw-1:0] shift_in;
    logic [cw-1:0] bit_cnt;
    logic          overrun;    // more than 16 rises in frame
    logic [dw-1:0] out_sr;
    logic [dw-1:0] rdata;
    logic [2:0]    rd_addr;
    logic [dw-1:0] mask_lo;
    logic [dw-1:0] mask_hi;

    // all three pins go through the same two stages so they stay aligned
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sync_1   <= 3'b100;  // ss_n idles high
            sync_2   <= 3'b100;
            sck_prev <= 1'b0;
            ss_prev  <= 1'b1;
        end else begin
            sync_1   <= {ss_n, sck, mosi};
            sync_2   <= sync_1;
            sck_prev <= sync_2[1];
            ss_prev  <= sync_2[2];
        end
    end

    assign sck_rise  = sync_2[1] & ~sck_prev & ~sync_2[2];
    assign sck_fall  = ~sync_2[1] & sck_prev & ~sync_2[2];
    assign frame_end = sync_2[2] & ~ss_prev;              // ss_n rising
    assign frame_ok  = frame_end && bit_cnt == cw'(fw) && !overrun;
    assign rd_addr   = {shift_in[1:0], sync_2[0]};        // valid on 4th rise

    always_comb begin
        case (rd_addr)
            trng_pkg::addr_thresh_0: rdata = thresh_0;
            trng_pkg::addr_thresh_1: rdata = thresh_1;
            trng_pkg::addr_thresh_2: rdata = thresh_2;
            trng_pkg::addr_thresh_3: rdata = thresh_3;
            trng_pkg::addr_mask_lo:  rdata = mask_lo;
            trng_pkg::addr_mask_hi:  rdata = mask_hi;
            default:                 rdata = '0;  // unmapped reads zero
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            bit_cnt        <= '0;
            overrun        <= 1'b0;
            miso           <= 1'b0;
            spi_data_ready <= 1'b0;
        end else begin
            spi_data_ready <= frame_ok;       // one pulse per good frame
            if (sync_2[2]) begin              // deselected
                bit_cnt <= '0;
                overrun <= 1'b0;
                miso    <= 1'b0;
            end else begin
                if (sck_rise) begin
                    if (bit_cnt == cw'(fw)) overrun <= 1'b1;
                    else                    bit_cnt <= bit_cnt + 1'b1;
                end
                if (sck_fall && bit_cnt >= cw'(fw - dw)) miso <= out_sr[dw-1];
            end
        end
    end

    // frame shifter and readback shifter
    always_ff @(posedge clk) begin
        if (sck_rise) shift_in <= {shift_in[fw-2:0], sync_2[0]};
        if (sck_rise && bit_cnt == cw'(fw - dw - 1)) begin
            out_sr <= rdata;                  // header complete, load register
        end else if (sck_fall && bit_cnt >= cw'(fw - dw)) begin
            out_sr <= {out_sr[dw-2:0], 1'b0};
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            thresh_0 <= '0;
            thresh_1 <= '0;
            thresh_2 <= '0;
            thresh_3 <= '0;
            mask_lo  <= '0;
            mask_hi  <= '0;
        end else if (frame_ok && shift_in[fw-1]) begin  // write frame
            case (shift_in[fw-2:dw])
                trng_pkg::addr_thresh_0: thresh_0 <= shift_in[dw-1:0];
                trng_pkg::addr_thresh_1: thresh_1 <= shift_in[dw-1:0];
                trng_pkg::addr_thresh_2: thresh_2 <= shift_in[dw-1:0];
                trng_pkg::addr_thresh_3: thresh_3 <= shift_in[dw-1:0];
                trng_pkg::addr_mask_lo:  mask_lo  <= shift_in[dw-1:0];
                trng_pkg::addr_mask_hi:  mask_hi  <= shift_in[dw-1:0];
                default: ;
            endcase
        end
    end

    assign source_mask = {{pad_w{1'b0}}, mask_hi, {pad_w{1'b0}}, mask_lo};

    a_bit_cnt_range: assert property (@(posedge clk) disable iff (!arst_n)
        !sync_2[2] |-> bit_cnt <= cw'(fw));

endmodule

`default_nettype wire

// File: verilog/ro_temp_control.sv
`timescale 1ns/1ps
`default_nettype none

module ro_temp_control #(
    parameter int meas_cycles = 64  // clk cycles per oscillator phase
) (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            en_in,
    input  logic [trng_pkg::temp_width-1:0] temp_in,   // ro counter
    input  logic [trng_pkg::temp_width-1:0] temp_cmp,  // threshold from spi
    output logic                            en_out1,
    output logic                            en_out2,
    output logic                            temp_alarm
);

    localparam int cw = $clog2(meas_cycles);

    logic [cw-1:0] phase_cnt;
    logic          sel;        // which oscillator runs
    logic          phase_end;

    assign phase_end = phase_cnt == cw'(meas_cycles - 1);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            phase_cnt  <= '0;
            sel        <= 1'b0;
            en_out1    <= 1'b0;
            en_out2    <= 1'b0;
            temp_alarm <= 1'b0;
        end else if (!en_in) begin     // monitor off, everything quiet
            phase_cnt  <= '0;
            sel        <= 1'b0;
            en_out1    <= 1'b0;
            en_out2    <= 1'b0;
            temp_alarm <= 1'b0;
        end else begin
            en_out1 <= ~sel;
            en_out2 <= sel;
            if (phase_end) begin
                phase_cnt  <= '0;
                sel        <= ~sel;
                temp_alarm <= temp_in > temp_cmp;  // sample at phase end
            end else begin
                phase_cnt <= phase_cnt + 1'b1;
            end
        end
    end

    a_one_osc: assert property (@(posedge clk) disable iff (!arst_n)
        !(en_out1 && en_out2));

endmodule

`default_nettype wire

// File: verilog/entropy_collector.sv
`timescale 1ns/1ps
`default_nettype none

module entropy_collector (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic [trng_pkg::num_sources-1:0]  entropy_source_array,
    input  logic [trng_pkg::num_sources-1:0]  source_mask,   // 1 drops a source
    input  logic                              word_take,
    output logic [trng_pkg::output_width-1:0] word,
    output logic                              word_valid
);

    localparam int ww = trng_pkg::output_width;
    localparam int cw = $clog2(ww);

    logic          fold_bit;
    logic [cw-1:0] fill_cnt;

    // parity of the unmasked sources
    assign fold_bit = ^(entropy_source_array & ~source_mask);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            fill_cnt   <= '0;
            word_valid <= 1'b0;
        end else if (word_valid) begin
            if (word_take) word_valid <= 1'b0;         // refill after take
        end else begin
            fill_cnt <= fill_cnt + 1'b1;               // wraps at 16
            if (fill_cnt == cw'(ww - 1)) word_valid <= 1'b1;
        end
    end

    // word held while valid
    always_ff @(posedge clk) begin
        if (!word_valid) word <= {word[ww-2:0], fold_bit};
    end

    a_take_valid: assert property (@(posedge clk) disable iff (!arst_n)
        word_take |-> word_valid);

endmodule

`default_nettype wire

// File: verilog/rand_req_engine.sv
`timescale 1ns/1ps
`default_nettype none

module rand_req_engine (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              rand_req,
    input  trng_pkg::rand_req_t               rand_req_type,
    input  logic [trng_pkg::output_width-1:0] word,
    input  logic                              word_valid,
    input  logic [trng_pkg::num_temp-1:0]     temp_alarm,
    output logic                              word_take,
    output logic [trng_pkg::output_width-1:0] rand_byte,
    output logic                              rand_valid
);

    localparam int ow = trng_pkg::output_width;
    localparam int nt = trng_pkg::num_temp;

    typedef enum logic [1:0] {
        idle,
        wait_first,
        wait_second,
        respond
    } state_t;

    state_t        state;
    logic          is_xor;
    logic          valid_echo;   // rand_valid one cycle late
    logic          use_word;     // request needs collector words
    logic [ow-1:0] first_word;
    logic [ow-1:0] status_word;

    assign status_word = {{(ow - nt){1'b0}}, temp_alarm};

    // any alarm turns raw and xor into status
    always_comb begin
        case (rand_req_type)
            trng_pkg::req_raw,
            trng_pkg::req_xor:    use_word = temp_alarm == '0;
            trng_pkg::req_status: use_word = 1'b0;
            default:              use_word = 1'b0;  // unknown codes as status
        endcase
    end

    // combinational so the collector drops valid before the next wait state
    assign word_take = (state == wait_first || state == wait_second) && word_valid;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state      <= idle;
            is_xor     <= 1'b0;
            valid_echo <= 1'b0;
            rand_valid <= 1'b0;
            rand_byte  <= '0;
            first_word <= '0;
        end else begin
            rand_valid <= 1'b0;
            valid_echo <= rand_valid;
            case (state)
                idle: begin
                    if (rand_req && !valid_echo) begin
                        if (use_word) begin
                            is_xor <= rand_req_type == trng_pkg::req_xor;
                            state  <= wait_first;
                        end else begin
                            rand_byte  <= status_word;  // answer next cycle
                            rand_valid <= 1'b1;
                            state      <= respond;
                        end
                    end
                end
                wait_first: begin
                    if (word_valid) begin
                        first_word <= word;
                        if (is_xor) begin
                            state <= wait_second;
                        end else begin
                            rand_byte  <= word;
                            rand_valid <= 1'b1;
                            state      <= respond;
                        end
                    end
                end
                wait_second: begin
                    if (word_valid) begin
                        rand_byte  <= first_word ^ word;
                        rand_valid <= 1'b1;
                        state      <= respond;
                    end
                end
                default: state <= idle;  // respond, valid is high here
            endcase
        end
    end

    a_valid_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        rand_valid |=> !rand_valid);

endmodule

`default_nettype wire

// File: verilog/trng_core.sv
`timescale 1ns/1ps
`default_nettype none

module trng_core (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              rand_req,
    input  trng_pkg::rand_req_t               rand_req_type,
    input  logic                              ss_n,
    input  logic                              sck,
    input  logic                              mosi,
    input  logic [trng_pkg::num_sources-1:0]  entropy_source_array,
    input  logic [trng_pkg::num_temp-1:0]     temp_alarm,
    output logic                              miso,
    output logic                              spi_data_ready,
    output logic [trng_pkg::temp_width-1:0]   thresh_0,
    output logic [trng_pkg::temp_width-1:0]   thresh_1,
    output logic [trng_pkg::temp_width-1:0]   thresh_2,
    output logic [trng_pkg::temp_width-1:0]   thresh_3,
    output logic [trng_pkg::output_width-1:0] rand_byte,
    output logic                              rand_valid
);

    logic [trng_pkg::num_sources-1:0]  source_mask;
    logic [trng_pkg::output_width-1:0] word;
    logic                              word_valid;
    logic                              word_take;

    spi_cfg_regs u_spi_cfg_regs (
        .clk            (clk),
        .arst_n         (arst_n),
        .ss_n           (ss_n),
        .sck            (sck),
        .mosi           (mosi),
        .miso           (miso),
        .spi_data_ready (spi_data_ready),
        .thresh_0       (thresh_0),
        .thresh_1       (thresh_1),
        .thresh_2       (thresh_2),
        .thresh_3       (thresh_3),
        .source_mask    (source_mask)
    );

    entropy_collector u_entropy_collector (
        .clk                  (clk),
        .arst_n               (arst_n),
        .entropy_source_array (entropy_source_array),
        .source_mask          (source_mask),
        .word_take            (word_take),
        .word                 (word),
        .word_valid           (word_valid)
    );

    rand_req_engine u_rand_req_engine (
        .clk           (clk),
        .arst_n        (arst_n),
        .rand_req      (rand_req),
        .rand_req_type (rand_req_type),
        .word          (word),
        .word_valid    (word_valid),
        .temp_alarm    (temp_alarm),
        .word_take     (word_take),
        .rand_byte     (rand_byte),
        .rand_valid    (rand_valid)
    );

endmodule

`default_nettype wire

// File: verilog/top_io.sv
`timescale 1ns/1ps
`default_nettype none

module top_io #(
    parameter int meas_cycles = 16  // temperature phase length
) (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              rand_req,
    input  trng_pkg::rand_req_t               rand_req_type,
    input  logic                              ss_n,
    input  logic                              sck,
    input  logic                              mosi,
    input  logic                              temp_debug,  // high stops monitors
    input  logic [trng_pkg::temp_width-1:0]   temp_counter_0,
    input  logic [trng_pkg::temp_width-1:0]   temp_counter_1,
    input  logic [trng_pkg::temp_width-1:0]   temp_counter_2,
    input  logic [trng_pkg::temp_width-1:0]   temp_counter_3,
    input  logic [trng_pkg::num_sources-1:0]  entropy_source_array,
    output logic [trng_pkg::output_width-1:0] rand_byte,
    output logic                              rand_valid,
    output logic                              miso,
    output logic                              spi_data_ready,
    output logic [trng_pkg::num_temp-1:0]     en_out1,
    output logic [trng_pkg::num_temp-1:0]     en_out2
);

    localparam int nt = trng_pkg::num_temp;

    logic                              rand_req_q;
    trng_pkg::rand_req_t               rand_req_type_q;
    logic                              ss_n_q;
    logic                              sck_q;
    logic                              mosi_q;
    logic                              temp_debug_q;
    logic [trng_pkg::temp_width-1:0]   counter_q [nt];   // ro counters
    logic [trng_pkg::num_sources-1:0]  entropy_q;
    logic [trng_pkg::temp_width-1:0]   thresh [nt];      // from spi regs
    logic [nt-1:0]                     temp_alarm;
    logic [nt-1:0]                     mon_en1;
    logic [nt-1:0]                     mon_en2;
    logic [trng_pkg::output_width-1:0] core_rand_byte;
    logic                              core_rand_valid;
    logic                              core_miso;
    logic                              core_spi_data_ready;

    // pad registers, control side
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rand_req_q      <= 1'b0;
            rand_req_type_q <= trng_pkg::req_raw;
            ss_n_q          <= 1'b1;             // deselected
            sck_q           <= 1'b0;
            temp_debug_q    <= 1'b1;             // monitors off in reset
            rand_valid      <= 1'b0;
            miso            <= 1'b0;
            spi_data_ready  <= 1'b0;
            en_out1         <= '0;
            en_out2         <= '0;
        end else begin
            rand_req_q      <= rand_req;
            rand_req_type_q <= rand_req_type;
            ss_n_q          <= ss_n;
            sck_q           <= sck;
            temp_debug_q    <= temp_debug;
            rand_valid      <= core_rand_valid;
            miso            <= core_miso;
            spi_data_ready  <= core_spi_data_ready;
            en_out1         <= mon_en1;
            en_out2         <= mon_en2;
        end
    end

    // pad registers, data side
    always_ff @(posedge clk) begin
        mosi_q       <= mosi;
        counter_q[0] <= temp_counter_0;
        counter_q[1] <= temp_counter_1;
        counter_q[2] <= temp_counter_2;
        counter_q[3] <= temp_counter_3;
        entropy_q    <= entropy_source_array;
        rand_byte    <= core_rand_byte;
    end

    for (genvar i = 0; i < nt; i++) begin : g_mon
        ro_temp_control #(
            .meas_cycles (meas_cycles)
        ) u_ro_temp_control (
            .clk        (clk),
            .arst_n     (arst_n),
            .en_in      (~temp_debug_q),
            .temp_in    (counter_q[i]),
            .temp_cmp   (thresh[i]),
            .en_out1    (mon_en1[i]),
            .en_out2    (mon_en2[i]),
            .temp_alarm (temp_alarm[i])
        );
    end

    trng_core u_trng_core (
        .clk                  (clk),
        .arst_n               (arst_n),
        .rand_req             (rand_req_q),
        .rand_req_type        (rand_req_type_q),
        .ss_n                 (ss_n_q),
        .sck                  (sck_q),
        .mosi                 (mosi_q),
        .entropy_source_array (entropy_q),
        .temp_alarm           (temp_alarm),
        .miso                 (core_miso),
        .spi_data_ready       (core_spi_data_ready),
        .thresh_0             (thresh[0]),
        .thresh_1             (thresh[1]),
        .thresh_2             (thresh[2]),
        .thresh_3             (thresh[3]),
        .rand_byte            (core_rand_byte),
        .rand_valid           (core_rand_valid)
    );

endmodule

`default_nettype wire

// File: verification/tb_top_io.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top_io;

    localparam int meas_cycles = 16;
    localparam int half_sck    = 6;      // clk cycles per sck half to cover miso round trip
    localparam int cycle_limit = 20000;  // well above 17 spi frames plus requests
    localparam int tw          = trng_pkg::temp_width;
    localparam int ow          = trng_pkg::output_width;
    localparam int ns          = trng_pkg::num_sources;
    localparam int nt          = trng_pkg::num_temp;
    localparam int fw          = trng_pkg::spi_frame_width;

    logic                clk;
    logic                arst_n;
    logic                rand_req;
    trng_pkg::rand_req_t rand_req_type;
    logic                ss_n;
    logic                sck;
    logic                mosi;
    logic                temp_debug;
    logic [tw-1:0]       temp_counter_0;
    logic [tw-1:0]       temp_counter_1;
    logic [tw-1:0]       temp_counter_2;
    logic [tw-1:0]       temp_counter_3;
    logic [ns-1:0]       entropy_source_array;
    logic [ow-1:0]       rand_byte;
    logic                rand_valid;
    logic                miso;
    logic                spi_data_ready;
    logic [nt-1:0]       en_out1;
    logic [nt-1:0]       en_out2;

    int            error_count = 0;
    int            check_count = 0;
    int            cycle_count = 0;
    logic [31:0]   rng_state;
    logic [tw-1:0] mask_lo_model;      // what the host last wrote
    logic [tw-1:0] mask_hi_model;

    top_io #(
        .meas_cycles (meas_cycles)
    ) u_top_io (
        .clk                  (clk),
        .arst_n               (arst_n),
        .rand_req             (rand_req),
        .rand_req_type        (rand_req_type),
        .ss_n                 (ss_n),
        .sck                  (sck),
        .mosi                 (mosi),
        .temp_debug           (temp_debug),
        .temp_counter_0       (temp_counter_0),
        .temp_counter_1       (temp_counter_1),
        .temp_counter_2       (temp_counter_2),
        .temp_counter_3       (temp_counter_3),
        .entropy_source_array (entropy_source_array),
        .rand_byte            (rand_byte),
        .rand_valid           (rand_valid),
        .miso                 (miso),
        .spi_data_ready       (spi_data_ready),
        .en_out1              (en_out1),
        .en_out2              (en_out2)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("Error: run did not finish within %0d cycles", cycle_limit);
            $display("checks run: %0d, errors: %0d", check_count, error_count + 1);
            $display("FAIL: see errors above");
            $finish;
        end
    end

    // every handshake and enable low in reset and one cycle past release
    a_reset_quiet: assert property (@(posedge clk)
        (!arst_n || !$past(arst_n)) |->
        (!rand_valid && !spi_data_ready && en_out1 == '0 && en_out2 == '0))
        else begin
            error_count++;
            $display("Error: outputs not quiet during or right after reset");
        end

    // three register stages from temp_debug pin to enable pins
    a_debug_off: assert property (@(posedge clk) disable iff (!arst_n)
        (temp_debug && $past(temp_debug, 1) && $past(temp_debug, 2) && $past(temp_debug, 3))
        |-> (en_out1 == '0 && en_out2 == '0))
        else begin
            error_count++;
            $display("Error: oscillator enable high while monitors are disabled");
        end

    a_one_enable: assert property (@(posedge clk) disable iff (!arst_n)
        (!temp_debug && !$past(temp_debug, 1) && !$past(temp_debug, 2)
         && !$past(temp_debug, 3) && $past(arst_n, 3))
        |-> ((en_out1 ^ en_out2) == '1))
        else begin
            error_count++;
            $display("Error: monitor without exactly one oscillator enable");
        end

    a_valid_pulse: assert property (@(posedge clk) disable iff (!arst_n)
        rand_valid |=> !rand_valid)
        else begin
            error_count++;
            $display("Error: rand_valid longer than one cycle");
        end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    // parity of kept sources copied to every output bit
    function automatic logic [ow-1:0] raw_expected(input logic [ns-1:0] src,
                                                  input logic [tw-1:0] lo,
                                                  input logic [tw-1:0] hi);
        logic [ns-1:0] keep;
        keep               = '1;
        keep[tw-1:0]       = ~lo;   // sources 0..11
        keep[ns/2 +: tw]   = ~hi;   // sources 32..43
        return {ow{^(src & keep)}};
    endfunction

    task automatic check_value(input string name, input logic [ow-1:0] exp,
                               input logic [ow-1:0] act);
        check_count++;
        assert (act === exp) else begin
            error_count++;
            $display("Error: %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // mode 0 frame with miso sampled at the end of each low half
    task automatic spi_xfer(input logic [fw-1:0] frame, output logic [tw-1:0] rdata);
        int seen;
        rdata = '0;
        seen  = 0;
        ss_n  = 1'b0;
        wait_cycles(half_sck);
        for (int i = fw - 1; i >= 0; i--) begin
            mosi = frame[i];
            sck  = 1'b0;
            wait_cycles(half_sck);
            if (i < tw) rdata[i] = miso;   // data bits follow the 4 header bits
            sck = 1'b1;
            wait_cycles(half_sck);
        end
        sck = 1'b0;
        wait_cycles(half_sck);
        ss_n = 1'b1;
        for (int n = 0; n < 12 && seen == 0; n++) begin
            @(negedge clk);
            if (spi_data_ready) seen = 1;
        end
        assert (seen == 1) else begin
            error_count++;
            $display("Error: no spi_data_ready pulse after frame %h", frame);
        end
        wait_cycles(4);
    endtask

    task automatic write_reg(input logic [2:0] addr, input logic [tw-1:0] data);
        logic [tw-1:0] unused_rd;
        spi_xfer({1'b1, addr, data}, unused_rd);
    endtask

    task automatic read_reg(input logic [2:0] addr, output logic [tw-1:0] data);
        spi_xfer({1'b0, addr, {tw{1'b0}}}, data);
    endtask

    // level request held until the valid pulse shows up
    task automatic request(input trng_pkg::rand_req_t kind, output logic [ow-1:0] result);
        rand_req      = 1'b1;
        rand_req_type = kind;
        @(negedge clk);
        while (!rand_valid) @(negedge clk);
        result   = rand_byte;
        rand_req = 1'b0;
        wait_cycles(3);            // request low between transactions
    endtask

    task automatic raw_after_flush(input string name, input logic [ow-1:0] exp);
        logic [ow-1:0] got;
        request(trng_pkg::req_raw, got);  // drops a word filled before the change
        request(trng_pkg::req_raw, got);
        check_value(name, exp, got);
    endtask

    initial begin
        logic [2:0]    addrs [6];
        logic [tw-1:0] wdata [6];
        logic [tw-1:0] rd;
        logic [ow-1:0] got;
        logic [ns-1:0] src;
        arst_n               = 1'b0;
        rand_req             = 1'b0;
        rand_req_type        = trng_pkg::req_raw;
        ss_n                 = 1'b1;
        sck                  = 1'b0;
        mosi                 = 1'b0;
        temp_debug           = 1'b0;
        temp_counter_0       = '0;    // zero counters keep alarms off
        temp_counter_1       = '0;
        temp_counter_2       = '0;
        temp_counter_3       = '0;
        entropy_source_array = '0;
        rng_state            = 32'd29994;
        addrs[0]             = trng_pkg::addr_thresh_0;
        addrs[1]             = trng_pkg::addr_thresh_1;
        addrs[2]             = trng_pkg::addr_thresh_2;
        addrs[3]             = trng_pkg::addr_thresh_3;
        addrs[4]             = trng_pkg::addr_mask_lo;
        addrs[5]             = trng_pkg::addr_mask_hi;
        repeat (10) @(negedge clk);
        arst_n = 1'b1;
        wait_cycles(4);

        for (int a = 0; a < 6; a++) begin
            wdata[a] = tw'(next_random());
            write_reg(addrs[a], wdata[a]);
        end
        for (int a = 0; a < 6; a++) begin
            read_reg(addrs[a], rd);
            check_value($sformatf("spi readback addr %0d", a), ow'(wdata[a]), ow'(rd));
        end
        mask_lo_model = wdata[4];
        mask_hi_model = wdata[5];

        src                  = {next_random(), next_random()};
        src[0]               = 1'b1;   // lets one mask bit flip the parity
        entropy_source_array = src;
        raw_after_flush("raw word", raw_expected(src, mask_lo_model, mask_hi_model));

        request(trng_pkg::req_xor, got);
        check_value("xor of constant words", '0, got);
        mask_lo_model = mask_lo_model ^ tw'(1);
        write_reg(trng_pkg::addr_mask_lo, mask_lo_model);
        raw_after_flush("raw after mask flip",
                        raw_expected(src, mask_lo_model, mask_hi_model));

        temp_counter_0 = 12'd50;
        temp_counter_1 = 12'd50;
        temp_counter_2 = 12'd50;
        temp_counter_3 = 12'd50;
        for (int m = 0; m < nt; m++) write_reg(addrs[m], 12'd100);
        wait_cycles(3 * meas_cycles + 8);
        request(trng_pkg::req_status, got);
        check_value("status below threshold", 16'h0000, got);
        temp_counter_2 = 12'd200;
        wait_cycles(3 * meas_cycles + 8);
        request(trng_pkg::req_status, got);
        check_value("status with alarm 2", 16'h0004, got);
        request(trng_pkg::req_raw, got);
        check_value("raw during alarm", 16'h0004, got);

        temp_debug = 1'b1;
        wait_cycles(6);
        request(trng_pkg::req_status, got);
        check_value("status with monitors off", 16'h0000, got);
        request(trng_pkg::req_raw, got);
        check_value("raw with monitors off", raw_expected(src, mask_lo_model, mask_hi_model),
                    got);
        wait_cycles(2 * meas_cycles);
        temp_debug = 1'b0;
        wait_cycles(3 * meas_cycles);

        $display("checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
verilog/trng_pkg.sv
verilog/spi_cfg_regs.sv
verilog/ro_temp_control.sv
verilog/entropy_collector.sv
verilog/rand_req_engine.sv
verilog/trng_core.sv
verilog/top_io.sv
verification/tb_top_io.sv

// File: run_sim.sh
#!/bin/sh
# build the top_io testbench with Verilator, run it, and check the log
rm -rf obj_dir sim.log
verilator --binary --assert --timing --top-module tb_top_io -f build.f -o sim_top_io \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/sim_top_io > sim.log 2>&1
cat sim.log
grep -qx "PASS: all tests" sim.log && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
